/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_cmd_poller
FILELIST := cmd_poller.f
BUILD    := obj_dir
SIM_BIN  := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* cmd/command_pulser.sv */
`timescale 1ns/1ps
`default_nettype none

module command_pulser (
    input  logic                          CLK,
    input  logic                          gen_reset,
    poll_if.cmd                           poll,
    output logic [mem_map_pkg::n_cmd-1:0] clear_req,  // Held until slot 0
    output logic [mem_map_pkg::n_cmd-1:0] cmd_pulse,  // One clock
    output logic [mem_map_pkg::n_cmd-1:0] cmd_level   // Five clocks from pulse
);

    logic at_check;  // Delayed byte valid
    logic at_frame_start;

    assign at_check       = (poll.phase == poll_timing_pkg::phase_check);
    assign at_frame_start = (poll.slot == '0);

    for (genvar i = 0; i < mem_map_pkg::n_cmd; i++)
    begin : g_ch
        // Byte address doubles as the read slot
        localparam mem_map_pkg::mem_addr_t ch_addr =
            (i == 0) ? mem_map_pkg::addr_cmd_rst   :
            (i == 1) ? mem_map_pkg::addr_cmd_init  :
            (i == 2) ? mem_map_pkg::addr_cmd_start :
                       mem_map_pkg::addr_cmd_stop;
        localparam mem_map_pkg::byte_t ch_code =
            (i == 1) ? mem_map_pkg::code_init : mem_map_pkg::code_go;

        logic cmd_fire;  // Code seen at phase 7 of own slot
        poll_timing_pkg::stretch_cnt_t stretch_cnt;

        assign cmd_fire = at_check &&
                          (poll.slot == poll_timing_pkg::slot_t'(ch_addr)) &&
                          (poll.read_word.raw == ch_code);

        // Pulse lands on the clock after phase 7
        always_ff @(posedge CLK)
        begin
            if (gen_reset)
                cmd_pulse[i] <= 1'b0;
            else
                cmd_pulse[i] <= cmd_fire;
        end

        // Loaded together with the pulse, counts down to 0
        always_ff @(posedge CLK)
        begin
            if (gen_reset)
                stretch_cnt <= '0;
            else if (cmd_fire)
                stretch_cnt <= poll_timing_pkg::stretch_cnt_t'(poll_timing_pkg::stretch_len);
            else if (stretch_cnt != '0)
                stretch_cnt <= stretch_cnt - 1'b1;
        end

        assign cmd_level[i] = (stretch_cnt != '0);

        // Asks write-back to zero the byte later this frame
        always_ff @(posedge CLK)
        begin
            if (gen_reset)
                clear_req[i] <= 1'b0;
            else if (at_frame_start)
                clear_req[i] <= 1'b0;
            else if (cmd_fire)
                clear_req[i] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* cmd/settings_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module settings_capture (
    input  logic                            CLK,
    input  logic                            gen_reset,
    poll_if.cmd                             poll,
    output logic [mem_map_pkg::row_w-1:0]   row_read_start,
    output logic [mem_map_pkg::row_w-1:0]   row_read_end,
    output logic [mem_map_pkg::col_w-1:0]   column_read_start,
    output logic [mem_map_pkg::col_w-1:0]   column_read_end,
    output logic [mem_map_pkg::chip_w-1:0]  chip_address
);

    logic late_phase;  // Phases 7..9, byte stable

    assign late_phase = (poll.phase >= poll_timing_pkg::phase_check);

    always_ff @(posedge CLK)
    begin
        if (gen_reset)
        begin
            row_read_start    <= '0;
            row_read_end      <= '0;
            column_read_start <= '0;
            column_read_end   <= '0;
            chip_address      <= '0;
        end
        else if (late_phase)
        begin
            case (poll.slot)
                poll_timing_pkg::slot_t'(mem_map_pkg::addr_chip):
                    chip_address <= poll.read_word.raw;  // Whole byte
                poll_timing_pkg::slot_t'(mem_map_pkg::addr_row_start):
                    row_read_start <= poll.read_word.row_view.row;
                poll_timing_pkg::slot_t'(mem_map_pkg::addr_row_end):
                    row_read_end <= poll.read_word.row_view.row;
                poll_timing_pkg::slot_t'(mem_map_pkg::addr_col_start):
                    column_read_start <= poll.read_word.col_view.col;
                poll_timing_pkg::slot_t'(mem_map_pkg::addr_col_end):
                    column_read_end <= poll.read_word.col_view.col;
                default:
                    ;  // Hold
            endcase
        end
    end

endmodule

`default_nettype wire

/* cmd_poller.f */
common/mem_map_pkg.sv
common/poll_timing_pkg.sv
common/poll_if.sv
hdl/poll_sequencer.sv
cmd/command_pulser.sv
cmd/settings_capture.sv
hdl/writeback_mux.sv
hdl/cmd_poller_top.sv
tests/cmd_poller_props.sv
tests/tb_cmd_poller.sv

/* common/mem_map_pkg.sv */
`default_nettype none

// Byte map of the 32-byte command memory
package mem_map_pkg;

    typedef logic [7:0] byte_t;      // One memory byte
    typedef logic [4:0] mem_addr_t;  // 32 locations

    localparam int n_cmd = 4;        // Reset, init, start, stop

    // Run control commands
    localparam mem_addr_t addr_cmd_rst   = 5'd1;
    localparam mem_addr_t addr_cmd_init  = 5'd2;
    localparam mem_addr_t addr_cmd_start = 5'd3;
    localparam mem_addr_t addr_cmd_stop  = 5'd4;
    localparam mem_addr_t addr_overflow  = 5'd7;   // Written every frame, never read

    // Readout settings
    localparam mem_addr_t addr_chip      = 5'd8;
    localparam mem_addr_t addr_row_start = 5'd10;
    localparam mem_addr_t addr_row_end   = 5'd11;
    localparam mem_addr_t addr_col_start = 5'd12;
    localparam mem_addr_t addr_col_end   = 5'd13;

    localparam byte_t code_go   = 8'h0F;  // Reset, start, stop
    localparam byte_t code_init = 8'h0A;

    localparam int row_w  = 6;
    localparam int col_w  = 4;
    localparam int chip_w = 8;

    // Polled byte, either whole or as a window field
    typedef union packed {
        byte_t raw;  // Command code or chip address
        struct packed {
            logic [7-row_w:0] pad;
            logic [row_w-1:0] row;
        } row_view;
        struct packed {
            logic [7-col_w:0] pad;
            logic [col_w-1:0] col;
        } col_view;
    } setting_word_u;

endpackage

`default_nettype wire

/* common/poll_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Time base and polled byte, from the sequencer to its consumers
interface poll_if ();

    poll_timing_pkg::slot_t     slot;       // Current slot
    poll_timing_pkg::phase_t    phase;      // Clock within slot
    mem_map_pkg::setting_word_u read_word;  // Byte of current slot from phase 7
    logic                       rd_en;      // Read strobe, slots 1 to 15
    mem_map_pkg::mem_addr_t     rd_addr;    // Zero outside read slots

    // Sequencer drives everything
    modport seq (
        output slot, phase, read_word, rd_en, rd_addr
    );

    // Command and settings decoders
    modport cmd (
        input slot, phase, read_word
    );

    // Write-back needs the read side to merge ports
    modport wb (
        input slot, phase, rd_en, rd_addr
    );

endinterface

`default_nettype wire

/* common/poll_timing_pkg.sv */
`default_nettype none

// Frame schedule of the poller
package poll_timing_pkg;

    typedef logic [3:0] phase_t;  // Clock within a slot
    typedef logic [5:0] slot_t;   // Slot within a frame

    localparam int     slot_len        = 10;    // Clocks per slot
    localparam int     slots_per_frame = 64;    // 640 clocks per frame

    localparam phase_t phase_advance  = 4'd1;   // Slot counter steps here
    localparam phase_t phase_check    = 4'd7;   // Delayed read data valid from here
    localparam phase_t phase_wr_first = 4'd2;   // Write strobe registered over 2..6
    localparam phase_t phase_wr_last  = 4'd6;

    localparam slot_t  first_read_slot = 6'd1;
    localparam slot_t  last_read_slot  = 6'd15;

    // Write-back slots, second half of frame
    localparam slot_t  slot_clr_rst   = 6'd33;
    localparam slot_t  slot_clr_init  = 6'd35;
    localparam slot_t  slot_clr_start = 6'd37;
    localparam slot_t  slot_clr_stop  = 6'd39;
    localparam slot_t  slot_overflow  = 6'd41;

    localparam int     stretch_len = 5;  // Level length incl. pulse clock
    typedef logic [$clog2(stretch_len+1)-1:0] stretch_cnt_t;

endpackage

`default_nettype wire

/* hdl/cmd_poller_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_poller_top (
    input  wire                     CLK,
    input  wire                     gen_reset,
    // Memory port B
    input  wire mem_map_pkg::byte_t     mem_rdata,
    output wire mem_map_pkg::byte_t     mem_wdata,
    output wire mem_map_pkg::mem_addr_t mem_addr,
    output wire                     mem_access_en,
    output wire                     mem_w_enable,
    input  wire                     fifo_overflow,
    // Readout window and chip select
    output wire [mem_map_pkg::row_w-1:0]  row_read_start,
    output wire [mem_map_pkg::row_w-1:0]  row_read_end,
    output wire [mem_map_pkg::col_w-1:0]  column_read_start,
    output wire [mem_map_pkg::col_w-1:0]  column_read_end,
    output wire mem_map_pkg::byte_t     chip_address,
    // Run control
    output wire                     rst,
    output wire                     rst_pulse,
    output wire                     init,
    output wire                     init_pulse,
    output wire                     start,
    output wire                     start_pulse,
    output wire                     stop,
    output wire                     stop_pulse
);

    wire [mem_map_pkg::n_cmd-1:0] clear_req;  // Bit 0 reset .. bit 3 stop

    poll_if poll ();

    poll_sequencer u_seq (
        .CLK       (CLK),
        .gen_reset (gen_reset),
        .mem_rdata (mem_rdata),
        .poll      (poll.seq)
    );

    // Channel order matches clear_req
    command_pulser u_cmd (
        .CLK       (CLK),
        .gen_reset (gen_reset),
        .poll      (poll.cmd),
        .clear_req (clear_req),
        .cmd_pulse ({stop_pulse, start_pulse, init_pulse, rst_pulse}),
        .cmd_level ({stop, start, init, rst})
    );

    settings_capture u_set (
        .CLK               (CLK),
        .gen_reset         (gen_reset),
        .poll              (poll.cmd),
        .row_read_start    (row_read_start),
        .row_read_end      (row_read_end),
        .column_read_start (column_read_start),
        .column_read_end   (column_read_end),
        .chip_address      (chip_address)
    );

    writeback_mux u_wb (
        .CLK           (CLK),
        .gen_reset     (gen_reset),
        .poll          (poll.wb),
        .clear_req     (clear_req),
        .fifo_overflow (fifo_overflow),
        .mem_wdata     (mem_wdata),
        .mem_addr      (mem_addr),
        .mem_access_en (mem_access_en),
        .mem_w_enable  (mem_w_enable)
    );

endmodule

`default_nettype wire

/* hdl/poll_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module poll_sequencer (
    input  logic               CLK,
    input  logic               gen_reset,
    input  mem_map_pkg::byte_t mem_rdata,  // One clock after rd_addr
    poll_if.seq                poll
);

    logic in_read_range;           // Slot falls in 1..15
    mem_map_pkg::byte_t rdata_d1;  // First delay stage

    // Phase counter, 0..9
    always_ff @(posedge CLK)
    begin
        if (gen_reset)
            poll.phase <= '0;
        else if (poll.phase == poll_timing_pkg::phase_t'(poll_timing_pkg::slot_len - 1))
            poll.phase <= '0;
        else
            poll.phase <= poll.phase + 1'b1;
    end

    // Slot counter steps once per slot, wraps at 64
    always_ff @(posedge CLK)
    begin
        if (gen_reset)
            poll.slot <= '0;
        else if (poll.phase == poll_timing_pkg::phase_advance)
        begin
            if (poll.slot == poll_timing_pkg::slot_t'(poll_timing_pkg::slots_per_frame - 1))
                poll.slot <= '0;
            else
                poll.slot <= poll.slot + 1'b1;
        end
    end

    assign in_read_range = (poll.slot >= poll_timing_pkg::first_read_slot) &&
                           (poll.slot <= poll_timing_pkg::last_read_slot);

    // Read slot k reads byte k; address must idle at 0 for the port OR
    always_ff @(posedge CLK)
    begin
        if (gen_reset)
        begin
            poll.rd_en   <= 1'b0;
            poll.rd_addr <= '0;
        end
        else
        begin
            poll.rd_en   <= in_read_range;
            poll.rd_addr <= in_read_range ? poll.slot[4:0] : '0;
        end
    end

    // Two-stage delay, valid from phase 6 onward
    always_ff @(posedge CLK)
    begin
        rdata_d1           <= mem_rdata;
        poll.read_word.raw <= rdata_d1;  // Decoded downstream
    end

endmodule

`default_nettype wire

/* hdl/writeback_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_mux (
    input  logic                          CLK,
    input  logic                          gen_reset,
    poll_if.wb                            poll,
    input  logic [mem_map_pkg::n_cmd-1:0] clear_req,
    input  logic                          fifo_overflow,
    output mem_map_pkg::byte_t            mem_wdata,
    output mem_map_pkg::mem_addr_t        mem_addr,
    output logic                          mem_access_en,
    output logic                          mem_w_enable
);

    logic                   in_window;  // Phases 2..6, strobe out on 3..7
    logic                   wr_hit;     // This slot owes a write
    mem_map_pkg::mem_addr_t hit_addr;
    mem_map_pkg::byte_t     hit_data;
    logic                   wr_strobe;
    mem_map_pkg::mem_addr_t wr_addr;    // Zero when idle

    assign in_window = (poll.phase >= poll_timing_pkg::phase_wr_first) &&
                       (poll.phase <= poll_timing_pkg::phase_wr_last);

    // Slot to write target
    always_comb
    begin
        wr_hit   = 1'b0;
        hit_addr = '0;
        hit_data = '0;  // Command clears write zero
        case (poll.slot)
            poll_timing_pkg::slot_clr_rst:
            begin
                wr_hit   = clear_req[0];
                hit_addr = mem_map_pkg::addr_cmd_rst;
            end
            poll_timing_pkg::slot_clr_init:
            begin
                wr_hit   = clear_req[1];
                hit_addr = mem_map_pkg::addr_cmd_init;
            end
            poll_timing_pkg::slot_clr_start:
            begin
                wr_hit   = clear_req[2];
                hit_addr = mem_map_pkg::addr_cmd_start;
            end
            poll_timing_pkg::slot_clr_stop:
            begin
                wr_hit   = clear_req[3];
                hit_addr = mem_map_pkg::addr_cmd_stop;
            end
            poll_timing_pkg::slot_overflow:
            begin
                wr_hit   = 1'b1;  // Every frame
                hit_addr = mem_map_pkg::addr_overflow;
                hit_data = mem_map_pkg::byte_t'(fifo_overflow);
            end
            default:
                ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (gen_reset)
        begin
            wr_strobe <= 1'b0;
            wr_addr   <= '0;
        end
        else if (wr_hit && in_window)
        begin
            wr_strobe <= 1'b1;
            wr_addr   <= hit_addr;
        end
        else
        begin
            wr_strobe <= 1'b0;
            wr_addr   <= '0;
        end
    end

    // Data only qualified by w_enable
    always_ff @(posedge CLK)
    begin
        if (wr_hit && in_window)
            mem_wdata <= hit_data;
    end

    // Reads only in slots 1..15 so the OR never collides
    assign mem_access_en = poll.rd_en | wr_strobe;
    assign mem_addr      = poll.rd_addr | wr_addr;
    assign mem_w_enable  = wr_strobe;

endmodule

`default_nettype wire

/* tests/cmd_poller_props.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_poller_props (
    input wire                          CLK,
    input wire                          gen_reset,
    input wire [mem_map_pkg::n_cmd-1:0] pulse,
    input wire [mem_map_pkg::n_cmd-1:0] level,
    input wire                          access_en,
    input wire                          w_enable
);

    for (genvar i = 0; i < mem_map_pkg::n_cmd; i++)
    begin : g_ch
        pulse_width: assert property (@(posedge CLK) disable iff (gen_reset)
            pulse[i] |=> !pulse[i])  // Single clock
            else $error("Command %0d pulse longer than one clock", i);

        level_start: assert property (@(posedge CLK) disable iff (gen_reset)
            $rose(level[i]) |-> pulse[i])
            else $error("Command %0d level rose without its pulse", i);

        // Falls five clocks after the pulse, so five clocks high
        level_end: assert property (@(posedge CLK) disable iff (gen_reset)
            $fell(level[i]) |-> $past(pulse[i], 5))
            else $error("Command %0d level not five clocks long", i);
    end

    // Port idle on the clock before a write
    write_from_idle: assert property (@(posedge CLK) disable iff (gen_reset)
        $rose(w_enable) |-> !$past(access_en))
        else $error("Memory write started while the port was busy");

    write_length: assert property (@(posedge CLK) disable iff (gen_reset)
        $fell(w_enable) |-> $past(w_enable, 5) && !$past(w_enable, 6))  // Phases 3 to 7
        else $error("Memory write strobe not five clocks long");

endmodule

bind command_pulser cmd_poller_props u_pulser_props (
    .CLK (CLK), .gen_reset (gen_reset), .pulse (cmd_pulse), .level (cmd_level),
    .access_en (1'b1), .w_enable (1'b0)  // No port here
);

bind writeback_mux cmd_poller_props u_wb_props (
    .CLK (CLK), .gen_reset (gen_reset),
    .pulse ({mem_map_pkg::n_cmd{1'b0}}), .level ({mem_map_pkg::n_cmd{1'b0}}),
    .access_en (mem_access_en), .w_enable (mem_w_enable)
);

`default_nettype wire

/* tests/tb_cmd_poller.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_poller;

    typedef logic [7:0] image_t [32];

    localparam int frame_cycles   = 640;
    localparam int first_load     = 492;                // Slot 50 of frame 0, port idle
    localparam int n_rounds       = 4;
    localparam int timeout_cycles = 12 * frame_cycles;  // Four rounds take under five frames

    logic       CLK = 1'b0;
    logic       gen_reset;
    logic       fifo_overflow;
    logic [7:0] mem_rdata = 8'h00;
    logic [7:0] mem_wdata;
    logic [4:0] mem_addr;
    logic       mem_access_en;
    logic       mem_w_enable;
    logic [5:0] row_read_start, row_read_end;
    logic [3:0] column_read_start, column_read_end;
    logic [7:0] chip_address;
    logic       rst, rst_pulse, init, init_pulse, start, start_pulse, stop, stop_pulse;

    image_t     mem;                 // Memory model contents
    image_t     load_img;            // Backdoor image, loaded on load_req
    logic       load_req;
    int         cyc = 0;             // Clocks since reset release
    int         next_load = first_load;
    int         frame_end_cyc = -1;
    int         frames_checked = 0;
    int         pulse_total [4] = '{default: 0};
    int         pulse_base [4];
    int         level_left [4] = '{default: 0};  // Level clocks still owed

    image_t     exp_mem;
    logic [3:0] exp_fire;
    logic [7:0] exp_chip;
    logic [5:0] exp_row_start, exp_row_end;
    logic [3:0] exp_col_start, exp_col_end;

    cmd_poller_top dut (
        .CLK (CLK), .gen_reset (gen_reset),
        .mem_rdata (mem_rdata), .mem_wdata (mem_wdata), .mem_addr (mem_addr),
        .mem_access_en (mem_access_en), .mem_w_enable (mem_w_enable),
        .fifo_overflow (fifo_overflow),
        .row_read_start (row_read_start), .row_read_end (row_read_end),
        .column_read_start (column_read_start), .column_read_end (column_read_end),
        .chip_address (chip_address),
        .rst (rst), .rst_pulse (rst_pulse), .init (init), .init_pulse (init_pulse),
        .start (start), .start_pulse (start_pulse), .stop (stop), .stop_pulse (stop_pulse)
    );

    always #10 CLK = ~CLK;  // 20 ns period

    always @(posedge CLK)
    begin : cycle_counter
        if (gen_reset)
            cyc <= 0;
        else
            cyc <= cyc + 1;
        if (cyc >= timeout_cycles)
        begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("=== FAIL ===");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // 32 bytes, one clock read latency
    always @(posedge CLK)
    begin : memory_model
        if (load_req)
        begin
            for (int a = 0; a < 32; a++)
                mem[a] <= load_img[a];
        end
        else if (mem_access_en && mem_w_enable)
            mem[mem_addr] <= mem_wdata;
        if (gen_reset)
            mem_rdata <= 8'h00;
        else if (mem_access_en && !mem_w_enable)
            mem_rdata <= mem[mem_addr];
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // One frame of polling applied to a memory image
    function automatic void predict_frame(
        input  image_t     img,
        input  logic       ovf,
        output image_t     nxt,
        output logic [3:0] fire,
        output logic [7:0] chip,
        output logic [5:0] row_s,
        output logic [5:0] row_e,
        output logic [3:0] col_s,
        output logic [3:0] col_e
    );
        nxt     = img;
        fire[0] = (img[1] == 8'h0F);  // Reset
        fire[1] = (img[2] == 8'h0A);  // Init, own code
        fire[2] = (img[3] == 8'h0F);  // Start
        fire[3] = (img[4] == 8'h0F);  // Stop
        for (int k = 0; k < 4; k++)
        begin
            if (fire[k])
                nxt[k + 1] = 8'h00;  // Cleared later in the frame
        end
        nxt[7] = {7'b0, ovf};
        chip   = img[8];
        row_s  = img[10][5:0];
        row_e  = img[11][5:0];
        col_s  = img[12][3:0];
        col_e  = img[13][3:0];
    endfunction

    task automatic wait_until(input int target);
        while (cyc < target)
            @(negedge CLK);
    endtask

    // Loads commands and settings, arms the check one frame later
    task automatic run_frame(input logic [3:0] go_mask, input logic ovf);
        logic [7:0] code;
        logic [7:0] v;
        wait_until(next_load);
        load_img = mem;
        for (int k = 0; k < 4; k++)
        begin
            code = (k == 1) ? 8'h0A : 8'h0F;
            v    = 8'($urandom);
            if (v == code)
                v = v ^ 8'h01;  // Keep wrong codes wrong
            load_img[k + 1] = go_mask[k] ? code : v;
        end
        load_img[8] = 8'($urandom);
        for (int a = 10; a <= 13; a++)
            load_img[a] = 8'($urandom);
        fifo_overflow = ovf;
        load_req      = 1'b1;
        predict_frame(load_img, ovf, exp_mem, exp_fire, exp_chip,
                      exp_row_start, exp_row_end, exp_col_start, exp_col_end);
        pulse_base    = pulse_total;
        frame_end_cyc = next_load + frame_cycles;
        @(negedge CLK);
        load_req  = 1'b0;
        next_load = next_load + frame_cycles + 10;  // One slot later each round
    endtask

    always @(negedge CLK)
    begin : compare_outputs
        logic [3:0] pulses;
        logic [3:0] levels;
        int         left;
        pulses = {stop_pulse, start_pulse, init_pulse, rst_pulse};
        levels = {stop, start, init, rst};
        if (cyc < 10)  // Quiet until slot 1 phase 7
        begin
            check_value("pulses, levels, write enable", 32'({pulses, levels, mem_w_enable}), 0);
            check_value("setting outputs", 32'({chip_address, row_read_start, row_read_end,
                        column_read_start, column_read_end}), 0);
        end
        if (!gen_reset)
        begin
            for (int k = 0; k < 4; k++)
            begin
                left = pulses[k] ? 5 : level_left[k];  // Pulse opens the level
                if (pulses[k])
                    pulse_total[k] = pulse_total[k] + 1;
                check_value($sformatf("level of command %0d", k), 32'(levels[k]),
                            32'(left != 0));
                level_left[k] = (left != 0) ? left - 1 : 0;
            end
        end
        if (cyc == frame_end_cyc)
        begin
            for (int k = 0; k < 4; k++)
                check_value($sformatf("pulses of command %0d", k),
                            32'(pulse_total[k] - pulse_base[k]), 32'(exp_fire[k]));
            check_value("chip_address", 32'(chip_address), 32'(exp_chip));
            check_value("row_read_start", 32'(row_read_start), 32'(exp_row_start));
            check_value("row_read_end", 32'(row_read_end), 32'(exp_row_end));
            check_value("column_read_start", 32'(column_read_start), 32'(exp_col_start));
            check_value("column_read_end", 32'(column_read_end), 32'(exp_col_end));
            for (int a = 0; a < 32; a++)
                check_value($sformatf("memory byte %0d", a), 32'(mem[a]), 32'(exp_mem[a]));
            frames_checked = frames_checked + 1;
        end
    end

    initial
    begin
        gen_reset     = 1'b1;
        fifo_overflow = 1'b0;
        load_req      = 1'b1;  // Fill pattern goes in during reset
        for (int a = 0; a < 32; a++)
            load_img[a] = 8'(a * 29) ^ 8'h6C;
        void'($urandom(32'h8086_4381));
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        gen_reset = 1'b0;
        load_req  = 1'b0;
        run_frame(4'b1111, 1'b1);  // Every command fires
        run_frame(4'b0000, 1'b0);  // Wrong codes only
        run_frame(4'b1001, 1'b1);  // Reset and stop
        run_frame(4'b0110, 1'b0);  // Init and start
        wait_until(frame_end_cyc + 1);
        if (frames_checked == n_rounds)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            $display("Only %0d of %0d frames were compared", frames_checked, n_rounds);
            $display("=== FAIL ===");
            $fatal(1, "Incomplete run");
        end
    end

endmodule

`default_nettype wire
